//--- all.f
+incdir+common
common/wg_axi_pkg.sv
common/wg_guard_pkg.sv
verilog/wg_prescaler.sv
write_guard/wg_slot_table.sv
write_guard/wg_w_order.sv
write_guard/wg_fault_report.sv
write_guard/write_guard.sv
testbench/write_guard_chk.sv
testbench/tb_write_guard.sv

//--- common/wg_axi_pkg.sv
// Write guard bus-side types
// Fields taken from the AW and B channels of the guarded write port
`include "wg_settings.svh"

package wg_axi_pkg;

  // Transaction ID, shared by AW and B
  typedef logic [`WG_ID_W-1:0] id_t;

  // Write address
  typedef logic [`WG_ADDR_W-1:0] addr_t;

  // Burst length, beats minus one
  typedef logic [`WG_LEN_W-1:0] len_t;

endpackage

//--- common/wg_guard_pkg.sv
// Write guard internal types
// Slot bookkeeping, phase encoding and fault causes
`include "wg_settings.svh"

package wg_guard_pkg;

  // Index into the slot table
  typedef logic [$clog2(`WG_MAX_TXNS)-1:0] slot_idx_t;

  // Tick counter and budget
  typedef logic [`WG_CNT_W-1:0] cnt_t;

  // Lifecycle of one write, IDLE marks a free slot
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ADDR = 2'd1,
    DATA = 2'd2,
    RESP = 2'd3
  } phase_e;

  // Reported violation
  typedef enum logic [2:0] {
    NONE         = 3'd0,
    AW_HS        = 3'd1,
    AW_TO_W      = 3'd2,
    W_BURST      = 3'd3,
    B_LATE       = 3'd4,
    B_UNEXPECTED = 3'd5
  } fault_e;

  // One tracked write
  typedef struct packed {
    wg_axi_pkg::id_t   id;
    wg_axi_pkg::addr_t addr;
    wg_axi_pkg::len_t  len;
    phase_e            phase;
    logic              aw_done;
    // AW handshake wait, then the current phase
    cnt_t              hs_cnt;
    cnt_t              ph_cnt;
    cnt_t              w_start_budget;
    cnt_t              w_burst_budget;
  } slot_t;

endpackage

//--- common/wg_settings.svh
// Write guard build settings
// Slot table depth, bus field widths, counter width and tick rate
`ifndef WG_SETTINGS_SVH
`define WG_SETTINGS_SVH

// Outstanding write transactions tracked at once
`define WG_MAX_TXNS 4

// Bus field widths
`define WG_ID_W 4
`define WG_ADDR_W 32
`define WG_LEN_W 8

// Tick counters and budgets
`define WG_CNT_W 16
`define WG_PRESCALE_DIV 4

`endif

//--- run.sh
#!/bin/sh
# Verilator build and run of the write guard testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_write_guard -o tb_write_guard &&
  ./obj_dir/tb_write_guard > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log && echo "Verdict: pass" || {
  echo "Verdict: fail"
  exit 1
}

//--- testbench/tb_write_guard.sv
// Write guard testbench
// Directed tests for retirement, same-ID bursts, handshake and burst
// timeouts, stray responses and a full slot table
`timescale 1ns/1ps
`include "wg_settings.svh"

module tb_write_guard;

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 10;
  // Cycle bounds of the six tests, in run order
  localparam int TEST_CYCLES  = 40 + 40 + 50 + 60 + 15 + 25;
  localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + TEST_CYCLES) * 2 * HALF_PERIOD;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 wr_en_i, wr_gnt_o;
  wg_axi_pkg::id_t      aw_id_i, b_id_i, irq_id_o;
  wg_axi_pkg::addr_t    aw_addr_i, irq_addr_o;
  wg_axi_pkg::len_t     aw_len_i;
  logic                 aw_valid_i, aw_ready_i, w_valid_i, w_ready_i, w_last_i;
  logic                 b_valid_i, b_ready_i, reset_clear_i;
  wg_guard_pkg::cnt_t   budget_aw_hs_i, unit_budget_w_i, budget_b_i;
  logic                 irq_o, reset_req_o;
  wg_guard_pkg::fault_e irq_cause_o;

  logic [31:0]          rng_state = 32'd13;
  wg_axi_pkg::id_t      fill_ids [`WG_MAX_TXNS];

  write_guard u_write_guard (.*);

  always #HALF_PERIOD clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic draw(output wg_axi_pkg::id_t id, output wg_axi_pkg::addr_t addr);
    rng_state = xorshift32(rng_state);
    id = rng_state[`WG_ID_W-1:0];
    rng_state = xorshift32(rng_state);
    // Word aligned
    addr = {rng_state[`WG_ADDR_W-1:2], 2'b00};
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_logic(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_cause(input string name, input wg_guard_pkg::fault_e got,
                             input wg_guard_pkg::fault_e exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_id(input string name, input wg_axi_pkg::id_t got,
                          input wg_axi_pkg::id_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input wg_axi_pkg::addr_t got,
                            input wg_axi_pkg::addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic clear_bus();
    wr_en_i       = 1'b0;
    aw_valid_i    = 1'b0;
    aw_ready_i    = 1'b0;
    w_valid_i     = 1'b0;
    w_ready_i     = 1'b0;
    w_last_i      = 1'b0;
    b_valid_i     = 1'b0;
    b_ready_i     = 1'b0;
    reset_clear_i = 1'b0;
  endtask

  // Each bus operation occupies one cycle, outputs are sampled at its rising edge
  task automatic enqueue(input wg_axi_pkg::id_t id, input wg_axi_pkg::addr_t addr,
                         input wg_axi_pkg::len_t len, input logic aw_hs);
    @(negedge clk_i);
    clear_bus();
    wr_en_i    = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_len_i   = len;
    aw_valid_i = 1'b1;
    aw_ready_i = aw_hs;
    @(posedge clk_i);
    check_logic("wr_gnt_o", wr_gnt_o, 1'b1);
  endtask

  task automatic w_beat(input logic last);
    @(negedge clk_i);
    clear_bus();
    w_valid_i = 1'b1;
    w_ready_i = 1'b1;
    w_last_i  = last;
    @(posedge clk_i);
  endtask

  task automatic b_resp(input wg_axi_pkg::id_t id);
    @(negedge clk_i);
    clear_bus();
    b_valid_i = 1'b1;
    b_ready_i = 1'b1;
    b_id_i    = id;
    @(posedge clk_i);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      clear_bus();
      @(posedge clk_i);
    end
  endtask

  task automatic wait_irq(input int bound);
    int waited;
    waited = 0;
    do begin
      idle(1);
      waited++;
    end while (!irq_o && waited < bound);
    if (!irq_o) begin
      abort_run($sformatf("irq_o did not rise within %0d cycles", bound));
    end
  endtask

  task automatic check_fault(input wg_guard_pkg::fault_e cause, input wg_axi_pkg::id_t id,
                             input logic hard);
    check_logic("irq_o", irq_o, 1'b1);
    check_cause("irq_cause_o", irq_cause_o, cause);
    check_id("irq_id_o", irq_id_o, id);
    check_logic("reset_req_o", reset_req_o, hard);
  endtask

  task automatic check_quiet();
    check_logic("irq_o", irq_o, 1'b0);
    check_logic("reset_req_o", reset_req_o, 1'b0);
  endtask

  task automatic clear_fault();
    @(negedge clk_i);
    clear_bus();
    reset_clear_i = 1'b1;
    @(posedge clk_i);
    idle(1);
    check_quiet();
    check_cause("irq_cause_o", irq_cause_o, wg_guard_pkg::NONE);
  endtask

  task automatic single_write();
    wg_axi_pkg::id_t   id;
    wg_axi_pkg::addr_t addr;
    draw(id, addr);
    enqueue(id, addr, '0, 1'b1);
    w_beat(1'b1);
    b_resp(id);
  endtask

  task automatic fill_table();
    wg_axi_pkg::addr_t addr;
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      draw(fill_ids[i], addr);
      enqueue(fill_ids[i], addr, '0, 1'b1);
    end
  endtask

  // W beats follow enqueue order, then responses in the same order
  task automatic drain_table();
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      w_beat(1'b1);
    end
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      b_resp(fill_ids[i]);
    end
  endtask

  task automatic test_back_to_back();
    for (int n = 0; n < 10; n++) begin
      single_write();
      check_quiet();
    end
  endtask

  task automatic test_same_id_bursts();
    wg_axi_pkg::id_t   id;
    wg_axi_pkg::addr_t addr_a;
    draw(id, addr_a);
    enqueue(id, addr_a, wg_axi_pkg::len_t'(3), 1'b1);
    enqueue(id, addr_a + 32'h40, wg_axi_pkg::len_t'(3), 1'b1);
    for (int beat = 0; beat < 8; beat++) begin
      w_beat(beat == 3 || beat == 7);
    end
    b_resp(id);
    b_resp(id);
    idle(2);
    check_quiet();
    fill_table();
    drain_table();
    idle(2);
    check_quiet();
  endtask

  task automatic test_aw_stall();
    wg_axi_pkg::id_t   id;
    wg_axi_pkg::addr_t addr;
    draw(id, addr);
    enqueue(id, addr, '0, 1'b0);
    // aw_ready stays low for the whole wait
    wait_irq(40);
    check_fault(wg_guard_pkg::AW_HS, id, 1'b1);
    check_addr("irq_addr_o", irq_addr_o, addr);
    clear_fault();
  endtask

  task automatic test_slow_burst();
    wg_axi_pkg::id_t   id;
    wg_axi_pkg::addr_t addr;
    draw(id, addr);
    enqueue(id, addr, wg_axi_pkg::len_t'(1), 1'b1);
    w_beat(1'b0);
    idle(39);
    w_beat(1'b1);
    check_fault(wg_guard_pkg::W_BURST, id, 1'b0);
    check_addr("irq_addr_o", irq_addr_o, addr);
    clear_fault();
    single_write();
    idle(4);
    check_quiet();
  endtask

  task automatic test_stray_response();
    wg_axi_pkg::id_t   id;
    wg_axi_pkg::addr_t addr;
    draw(id, addr);
    b_resp(id);
    wait_irq(4);
    check_fault(wg_guard_pkg::B_UNEXPECTED, id, 1'b1);
    clear_fault();
  endtask

  task automatic test_full_table();
    fill_table();
    idle(1);
    check_logic("wr_gnt_o", wr_gnt_o, 1'b0);
    drain_table();
    idle(4);
    check_quiet();
  endtask

  initial begin
    rst_ni          = 1'b0;
    clear_bus();
    aw_id_i         = '0;
    aw_addr_i       = '0;
    aw_len_i        = '0;
    b_id_i          = '0;
    budget_aw_hs_i  = wg_guard_pkg::cnt_t'(3);
    unit_budget_w_i = wg_guard_pkg::cnt_t'(4);
    budget_b_i      = wg_guard_pkg::cnt_t'(3);
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_quiet();
    check_cause("irq_cause_o", irq_cause_o, wg_guard_pkg::NONE);
    check_logic("wr_gnt_o", wr_gnt_o, 1'b1);
    test_back_to_back();
    test_same_id_bursts();
    test_aw_stall();
    test_slow_burst();
    test_stray_response();
    test_full_table();
    if (u_write_guard.u_write_guard_chk.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run("Checker assertions failed during the run");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before all tests completed");
  end

endmodule

//--- testbench/write_guard_chk.sv
// Write guard protocol checker
// Concurrent assertions on the interrupt outputs and the grant after a flush
`timescale 1ns/1ps

module write_guard_chk (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 irq_i,
  input logic                 reset_req_i,
  input wg_guard_pkg::fault_e irq_cause_i,
  input logic                 flush_i,
  input logic                 wr_gnt_i
);

  // Failed assertions so far
  int fail_cnt = 0;

  irq_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_i |-> irq_cause_i != wg_guard_pkg::NONE)
  else begin
    $error("irq raised while the held cause is NONE");
    fail_cnt++;
  end

  reset_req_needs_irq: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reset_req_i |-> irq_i)
  else begin
    $error("reset request raised without an interrupt");
    fail_cnt++;
  end

  // Flush frees every slot, so a grant must follow
  gnt_after_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> wr_gnt_i)
  else begin
    $error("no write grant in the cycle after a flush");
    fail_cnt++;
  end

endmodule

bind write_guard write_guard_chk u_write_guard_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .irq_i       (irq_o),
  .reset_req_i (reset_req_o),
  .irq_cause_i (irq_cause_o),
  .flush_i     (flush),
  .wr_gnt_i    (wr_gnt_o)
);

//--- verilog/wg_prescaler.sv
// Write guard prescaler
// One-cycle tick every WG_PRESCALE_DIV clocks, paces all phase counters
`timescale 1ns/1ps
`include "wg_settings.svh"

module wg_prescaler (
  input  logic clk_i,
  input  logic rst_ni,
  output logic tick_o
);

  logic [$clog2(`WG_PRESCALE_DIV)-1:0] div_cnt_q;

  // Last count of the period
  assign tick_o = (div_cnt_q == ($clog2(`WG_PRESCALE_DIV))'(`WG_PRESCALE_DIV - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_cnt_q <= '0;
    end else if (tick_o) begin
      div_cnt_q <= '0;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

endmodule

//--- write_guard/wg_fault_report.sv
// Write guard fault report
// Latches the first fault into the interrupt outputs, raises a reset
// request for hard faults and flushes the slot table once per capture
`timescale 1ns/1ps

module wg_fault_report (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fault_valid_i,
  input  wg_guard_pkg::fault_e fault_cause_i,
  input  wg_axi_pkg::id_t      fault_id_i,
  input  wg_axi_pkg::addr_t    fault_addr_i,
  input  logic                 reset_clear_i,
  output logic                 irq_o,
  output logic                 reset_req_o,
  output wg_guard_pkg::fault_e irq_cause_o,
  output wg_axi_pkg::id_t      irq_id_o,
  output wg_axi_pkg::addr_t    irq_addr_o,
  output logic                 flush_o
);

  logic capture;
  logic flush_q;

  // Handshake and response faults need a bus reset
  function automatic logic is_hard(input wg_guard_pkg::fault_e cause);
    return (cause == wg_guard_pkg::AW_HS) || (cause == wg_guard_pkg::B_LATE) ||
           (cause == wg_guard_pkg::B_UNEXPECTED);
  endfunction

  // Only the first fault is kept until software clears it
  assign capture = fault_valid_i && !irq_o && !reset_clear_i;
  assign flush_o = flush_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_o       <= 1'b0;
      reset_req_o <= 1'b0;
      irq_cause_o <= wg_guard_pkg::NONE;
      irq_id_o    <= '0;
      irq_addr_o  <= '0;
      flush_q     <= 1'b0;
    end else begin
      flush_q <= capture;
      if (reset_clear_i) begin
        irq_o       <= 1'b0;
        reset_req_o <= 1'b0;
        irq_cause_o <= wg_guard_pkg::NONE;
        irq_id_o    <= '0;
        irq_addr_o  <= '0;
      end else if (capture) begin
        irq_o       <= 1'b1;
        reset_req_o <= is_hard(fault_cause_i);
        irq_cause_o <= fault_cause_i;
        irq_id_o    <= fault_id_i;
        irq_addr_o  <= fault_addr_i;
      end
    end
  end

endmodule

//--- write_guard/wg_slot_table.sv
// Write guard slot table
// Tracks each outstanding write through its AW, W and B phases, times every
// phase in prescaled ticks and flags the first budget violation
`timescale 1ns/1ps
`include "wg_settings.svh"

module wg_slot_table (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    tick_i,
  // Enqueue from the master
  input  logic                    wr_en_i,
  input  wg_axi_pkg::id_t         aw_id_i,
  input  wg_axi_pkg::addr_t       aw_addr_i,
  input  wg_axi_pkg::len_t        aw_len_i,
  // AW handshake, already qualified by aw_valid at the top level
  input  logic                    aw_ready_i,
  input  logic                    w_valid_i,
  input  logic                    w_ready_i,
  input  logic                    w_last_i,
  input  logic                    b_valid_i,
  input  logic                    b_ready_i,
  input  wg_axi_pkg::id_t         b_id_i,
  input  wg_guard_pkg::cnt_t      budget_aw_hs_i,
  input  wg_guard_pkg::cnt_t      unit_budget_w_i,
  input  wg_guard_pkg::cnt_t      budget_b_i,
  // Current W channel owner
  input  wg_guard_pkg::slot_idx_t head_idx_i,
  input  logic                    head_valid_i,
  input  logic                    flush_i,
  output logic                    wr_gnt_o,
  output logic                    push_o,
  output wg_guard_pkg::slot_idx_t push_idx_o,
  output logic                    pop_o,
  output logic                    fault_valid_o,
  output wg_guard_pkg::fault_e    fault_cause_o,
  output wg_axi_pkg::id_t         fault_id_o,
  output wg_axi_pkg::addr_t       fault_addr_o
);

  wg_guard_pkg::slot_t     slot_q [`WG_MAX_TXNS];
  wg_guard_pkg::slot_t     slot_d [`WG_MAX_TXNS];
  // Unserved AW handshakes owed to older slots
  wg_guard_pkg::slot_idx_t aw_ahead_q [`WG_MAX_TXNS];
  wg_guard_pkg::slot_idx_t aw_ahead_d [`WG_MAX_TXNS];

  logic [`WG_MAX_TXNS-1:0] is_head;
  logic                    any_free, retire_hit, retire, b_hs, w_last_hs, enq;
  wg_guard_pkg::slot_idx_t free_idx, retire_idx, alloc_idx, pend_cnt;
  wg_guard_pkg::cnt_t      beats_ahead, own_beats;

  assign b_hs      = b_valid_i && b_ready_i;
  assign w_last_hs = w_valid_i && w_ready_i && w_last_i;
  assign retire    = b_hs && retire_hit;

  // A retiring slot can be reused in the same cycle
  assign wr_gnt_o   = any_free || retire;
  assign alloc_idx  = any_free ? free_idx : retire_idx;
  assign enq        = wr_en_i && wr_gnt_o;
  assign push_o     = enq;
  assign push_idx_o = alloc_idx;
  assign pop_o      = head_valid_i && w_last_hs;
  assign own_beats  = wg_guard_pkg::cnt_t'(aw_len_i) + 1'b1;

  // Free slot and retire target, downward scan so the lowest index wins
  always_comb begin
    any_free   = 1'b0;
    free_idx   = '0;
    retire_hit = 1'b0;
    retire_idx = '0;
    for (int i = `WG_MAX_TXNS - 1; i >= 0; i--) begin
      is_head[i] = head_valid_i && (head_idx_i == wg_guard_pkg::slot_idx_t'(i));
      if (slot_q[i].phase == wg_guard_pkg::IDLE) begin
        any_free = 1'b1;
        free_idx = wg_guard_pkg::slot_idx_t'(i);
      end
      if (slot_q[i].phase == wg_guard_pkg::RESP && slot_q[i].id == b_id_i) begin
        retire_hit = 1'b1;
        retire_idx = wg_guard_pkg::slot_idx_t'(i);
      end
    end
  end

  // Load left in the table once this cycle's retire and flush are applied
  always_comb begin
    beats_ahead = '0;
    pend_cnt    = '0;
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      if (slot_q[i].phase != wg_guard_pkg::IDLE && !flush_i &&
          !(retire && retire_idx == wg_guard_pkg::slot_idx_t'(i))) begin
        beats_ahead = beats_ahead + wg_guard_pkg::cnt_t'(slot_q[i].len) + 1'b1;
        if (!slot_q[i].aw_done) begin
          pend_cnt = pend_cnt + 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `WG_MAX_TXNS; i++) begin
      slot_d[i]     = slot_q[i];
      aw_ahead_d[i] = aw_ahead_q[i];
      if (slot_q[i].phase != wg_guard_pkg::IDLE) begin
        // AW handshakes complete in enqueue order
        if (!slot_q[i].aw_done) begin
          if (aw_ready_i) begin
            if (aw_ahead_q[i] == '0) begin
              slot_d[i].aw_done = 1'b1;
            end else begin
              aw_ahead_d[i] = aw_ahead_q[i] - 1'b1;
            end
          end else if (tick_i) begin
            slot_d[i].hs_cnt = slot_q[i].hs_cnt + 1'b1;
          end
        end
        case (slot_q[i].phase)
          wg_guard_pkg::ADDR: begin
            // First beat may also be the last one
            if (is_head[i] && w_valid_i) begin
              slot_d[i].ph_cnt = '0;
              slot_d[i].phase  = (w_ready_i && w_last_i) ? wg_guard_pkg::RESP
                                                         : wg_guard_pkg::DATA;
            end else if (tick_i) begin
              slot_d[i].ph_cnt = slot_q[i].ph_cnt + 1'b1;
            end
          end
          wg_guard_pkg::DATA: begin
            if (is_head[i] && w_last_hs) begin
              slot_d[i].ph_cnt = '0;
              slot_d[i].phase  = wg_guard_pkg::RESP;
            end else if (tick_i) begin
              slot_d[i].ph_cnt = slot_q[i].ph_cnt + 1'b1;
            end
          end
          wg_guard_pkg::RESP: begin
            if (tick_i && !(b_valid_i && b_id_i == slot_q[i].id)) begin
              slot_d[i].ph_cnt = slot_q[i].ph_cnt + 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
      if (flush_i) begin
        slot_d[i].phase = wg_guard_pkg::IDLE;
      end
    end
    if (retire) begin
      slot_d[retire_idx].phase = wg_guard_pkg::IDLE;
    end
    if (enq) begin
      // W-start budget covers every beat queued ahead plus our own
      slot_d[alloc_idx] = '{
        id:             aw_id_i,
        addr:           aw_addr_i,
        len:            aw_len_i,
        phase:          wg_guard_pkg::ADDR,
        aw_done:        aw_ready_i && (pend_cnt == '0),
        hs_cnt:         '0,
        ph_cnt:         '0,
        w_start_budget: unit_budget_w_i * (beats_ahead + own_beats),
        w_burst_budget: unit_budget_w_i * own_beats
      };
      aw_ahead_d[alloc_idx] = (aw_ready_i && pend_cnt != '0) ? pend_cnt - 1'b1 : pend_cnt;
    end
  end

  // Lowest slot first, then the earliest phase within it
  always_comb begin
    wg_guard_pkg::fault_e slot_cause;
    fault_valid_o = 1'b0;
    fault_cause_o = wg_guard_pkg::NONE;
    fault_id_o    = '0;
    fault_addr_o  = '0;
    for (int i = `WG_MAX_TXNS - 1; i >= 0; i--) begin
      slot_cause = wg_guard_pkg::NONE;
      if (slot_q[i].phase != wg_guard_pkg::IDLE && !slot_q[i].aw_done &&
          slot_q[i].hs_cnt > budget_aw_hs_i) begin
        slot_cause = wg_guard_pkg::AW_HS;
      end else if (slot_q[i].phase == wg_guard_pkg::ADDR &&
                   slot_q[i].ph_cnt > slot_q[i].w_start_budget) begin
        slot_cause = wg_guard_pkg::AW_TO_W;
      end else if (slot_q[i].phase == wg_guard_pkg::DATA &&
                   slot_q[i].ph_cnt > slot_q[i].w_burst_budget) begin
        slot_cause = wg_guard_pkg::W_BURST;
      end else if (slot_q[i].phase == wg_guard_pkg::RESP &&
                   slot_q[i].ph_cnt > budget_b_i) begin
        slot_cause = wg_guard_pkg::B_LATE;
      end
      if (slot_cause != wg_guard_pkg::NONE) begin
        fault_valid_o = 1'b1;
        fault_cause_o = slot_cause;
        fault_id_o    = slot_q[i].id;
        fault_addr_o  = slot_q[i].addr;
      end
    end
    // Stray response has no slot and no address
    if (!fault_valid_o && b_hs && !retire_hit) begin
      fault_valid_o = 1'b1;
      fault_cause_o = wg_guard_pkg::B_UNEXPECTED;
      fault_id_o    = b_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `WG_MAX_TXNS; i++) begin
        slot_q[i]     <= '0;
        aw_ahead_q[i] <= '0;
      end
    end else begin
      slot_q     <= slot_d;
      aw_ahead_q <= aw_ahead_d;
    end
  end

endmodule

//--- write_guard/wg_w_order.sv
// Write guard W ownership queue
// Slot indices in enqueue order, the head owns the W channel
`timescale 1ns/1ps
`include "wg_settings.svh"

module wg_w_order (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  wg_guard_pkg::slot_idx_t push_idx_i,
  input  logic                    pop_i,
  input  logic                    flush_i,
  output wg_guard_pkg::slot_idx_t head_idx_o,
  output logic                    not_empty_o
);

  wg_guard_pkg::slot_idx_t        mem [`WG_MAX_TXNS];
  wg_guard_pkg::slot_idx_t        rd_ptr_q, wr_ptr_q, rd_ptr_nxt, wr_ptr_nxt;
  logic [$clog2(`WG_MAX_TXNS):0]  count_q;
  logic                           do_pop;

  assign not_empty_o = (count_q != '0);
  assign head_idx_o  = mem[rd_ptr_q];
  assign do_pop      = pop_i && not_empty_o;

  // Circular pointers
  assign rd_ptr_nxt = (rd_ptr_q == wg_guard_pkg::slot_idx_t'(`WG_MAX_TXNS - 1)) ? '0
                                                                                : rd_ptr_q + 1'b1;
  assign wr_ptr_nxt = (wr_ptr_q == wg_guard_pkg::slot_idx_t'(`WG_MAX_TXNS - 1)) ? '0
                                                                                : wr_ptr_q + 1'b1;

  // On flush a concurrent push lands in entry zero
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[flush_i ? '0 : wr_ptr_q] <= push_idx_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= push_i ? wg_guard_pkg::slot_idx_t'(1) : '0;
      count_q  <= push_i ? 1'b1 : '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_nxt;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_nxt;
      end
      if (push_i && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- write_guard/write_guard.sv
// Write guard top level
// Watches a write channel per transaction and interrupts on phase timeouts
// or stray responses
`timescale 1ns/1ps

module write_guard (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Transaction enqueue
  input  logic                 wr_en_i,
  input  wg_axi_pkg::id_t      aw_id_i,
  input  wg_axi_pkg::addr_t    aw_addr_i,
  input  wg_axi_pkg::len_t     aw_len_i,
  output logic                 wr_gnt_o,
  // Observed bus levels
  input  logic                 aw_valid_i,
  input  logic                 aw_ready_i,
  input  logic                 w_valid_i,
  input  logic                 w_ready_i,
  input  logic                 w_last_i,
  input  logic                 b_valid_i,
  input  logic                 b_ready_i,
  input  wg_axi_pkg::id_t      b_id_i,
  // Static budgets in ticks
  input  wg_guard_pkg::cnt_t   budget_aw_hs_i,
  input  wg_guard_pkg::cnt_t   unit_budget_w_i,
  input  wg_guard_pkg::cnt_t   budget_b_i,
  // Fault report
  input  logic                 reset_clear_i,
  output logic                 irq_o,
  output logic                 reset_req_o,
  output wg_guard_pkg::fault_e irq_cause_o,
  output wg_axi_pkg::id_t      irq_id_o,
  output wg_axi_pkg::addr_t    irq_addr_o
);

  logic                    tick, push, pop, head_valid, flush, fault_valid;
  wg_guard_pkg::slot_idx_t push_idx, head_idx;
  wg_guard_pkg::fault_e    fault_cause;
  wg_axi_pkg::id_t         fault_id;
  wg_axi_pkg::addr_t       fault_addr;

  wg_prescaler u_prescaler (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tick_o (tick)
  );

  wg_slot_table u_slot_table (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .tick_i          (tick),
    .wr_en_i         (wr_en_i),
    .aw_id_i         (aw_id_i),
    .aw_addr_i       (aw_addr_i),
    .aw_len_i        (aw_len_i),
    .aw_ready_i      (aw_valid_i && aw_ready_i),
    .w_valid_i       (w_valid_i),
    .w_ready_i       (w_ready_i),
    .w_last_i        (w_last_i),
    .b_valid_i       (b_valid_i),
    .b_ready_i       (b_ready_i),
    .b_id_i          (b_id_i),
    .budget_aw_hs_i  (budget_aw_hs_i),
    .unit_budget_w_i (unit_budget_w_i),
    .budget_b_i      (budget_b_i),
    .head_idx_i      (head_idx),
    .head_valid_i    (head_valid),
    .flush_i         (flush),
    .wr_gnt_o        (wr_gnt_o),
    .push_o          (push),
    .push_idx_o      (push_idx),
    .pop_o           (pop),
    .fault_valid_o   (fault_valid),
    .fault_cause_o   (fault_cause),
    .fault_id_o      (fault_id),
    .fault_addr_o    (fault_addr)
  );

  wg_w_order u_w_order (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_idx_i  (push_idx),
    .pop_i       (pop),
    .flush_i     (flush),
    .head_idx_o  (head_idx),
    .not_empty_o (head_valid)
  );

  wg_fault_report u_fault_report (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fault_valid_i (fault_valid),
    .fault_cause_i (fault_cause),
    .fault_id_i    (fault_id),
    .fault_addr_i  (fault_addr),
    .reset_clear_i (reset_clear_i),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o),
    .irq_cause_o   (irq_cause_o),
    .irq_id_o      (irq_id_o),
    .irq_addr_o    (irq_addr_o),
    .flush_o       (flush)
  );

endmodule
